/* logic/rename_pkg.sv */
package rename_pkg;

    // ===================================================================
    // machine sizes
    // ===================================================================
    localparam int unsigned DISPATCH_WIDTH = 2;
    localparam int unsigned COMMIT_WIDTH   = 2;
    localparam int unsigned ARCH_REGS      = 32;
    localparam int unsigned PHYS_REGS      = 64;
    // registers not holding architectural state after reset
    localparam int unsigned FREE_REGS      = PHYS_REGS - ARCH_REGS;

    localparam int unsigned ARCH_IDX_W = $clog2(ARCH_REGS);
    localparam int unsigned PHYS_IDX_W = $clog2(PHYS_REGS);
    // count has to reach FREE_REGS itself
    localparam int unsigned FREE_CNT_W = $clog2(FREE_REGS + 1);
    // queue pointers, wrap for free since FREE_REGS is a power of two
    localparam int unsigned FREE_PTR_W = $clog2(FREE_REGS);
    localparam int unsigned REL_CNT_W  = $clog2(COMMIT_WIDTH + 1);
    localparam int unsigned REQ_CNT_W  = $clog2(DISPATCH_WIDTH + 1);

    typedef logic [ARCH_IDX_W-1:0] arch_idx_t;
    typedef logic [PHYS_IDX_W-1:0] phys_idx_t;

    // ===================================================================
    // dispatch side
    // ===================================================================
    typedef struct packed {
        logic      dest_valid;
        arch_idx_t dest_arch;
        arch_idx_t src1_arch;
        arch_idx_t src2_arch;
    } rename_slot_t;

    // slot 0 is the older instruction
    typedef struct packed {
        logic                              valid;
        rename_slot_t [DISPATCH_WIDTH-1:0] slots;
    } rename_group_t;

    typedef phys_idx_t [DISPATCH_WIDTH-1:0] alloc_phys_t;

    typedef struct packed {
        logic      dest_valid;
        phys_idx_t dest_phys;
        phys_idx_t old_dest_phys;
        phys_idx_t src1_phys;
        phys_idx_t src2_phys;
    } renamed_uop_t;

    typedef renamed_uop_t [DISPATCH_WIDTH-1:0] renamed_group_t;

    // ===================================================================
    // commit side
    // ===================================================================
    // old mapping given up by a retiring instruction
    typedef struct packed {
        logic      valid;
        phys_idx_t old_phys;
    } release_t;

    typedef release_t [COMMIT_WIDTH-1:0] release_list_t;

endpackage

/* logic/retire_release.sv */
`timescale 1ns/1ps

module retire_release (
    input  rename_pkg::release_list_t          commit_i,
    output rename_pkg::release_list_t          release_list_o,
    output logic [rename_pkg::REL_CNT_W-1:0]   release_count_o
);

    // per-slot keep flags
    logic [rename_pkg::COMMIT_WIDTH-1:0] keep;

    // ===================================================================
    // filter
    // ===================================================================
    // p0 backs r0 for good, never goes back on the free list
    always_comb begin
        for (int i = 0; i < rename_pkg::COMMIT_WIDTH; i++) begin
            keep[i] = commit_i[i].valid && (commit_i[i].old_phys != '0);
        end
    end

    // ===================================================================
    // compaction
    // ===================================================================
    // kept slots move down to the low entries, commit order preserved
    // so the free list can write one contiguous run at its tail
    always_comb begin
        release_list_o  = '0;
        release_count_o = '0;
        for (int i = 0; i < rename_pkg::COMMIT_WIDTH; i++) begin
            if (keep[i]) begin
                // running count doubles as the write position
                release_list_o[release_count_o].valid    = 1'b1;
                release_list_o[release_count_o].old_phys = commit_i[i].old_phys;
                release_count_o = release_count_o + 1'b1;
            end
        end
    end

    // unused upper entries stay zero, valid low
    // count runs 0 to COMMIT_WIDTH

endmodule

/* logic/free_list.sv */
`timescale 1ns/1ps

module free_list (
    input  logic                                   clock,
    input  logic                                   reset,
    input  logic [rename_pkg::DISPATCH_WIDTH-1:0]  alloc_req_i,
    input  rename_pkg::release_list_t              release_list_i,
    input  logic [rename_pkg::REL_CNT_W-1:0]       release_count_i,
    output rename_pkg::alloc_phys_t                alloc_phys_o,
    output logic                                   alloc_ok_o,
    output logic [rename_pkg::FREE_CNT_W-1:0]      free_count_o
);

    // circular queue of free physical registers
    rename_pkg::phys_idx_t                 queue_q [rename_pkg::FREE_REGS];
    // head is the oldest free entry, tail the next write slot
    logic [rename_pkg::FREE_PTR_W-1:0]     head_q;
    logic [rename_pkg::FREE_PTR_W-1:0]     tail_q;
    logic [rename_pkg::FREE_CNT_W-1:0]     count_q;

    // request and availability bookkeeping
    logic [rename_pkg::REQ_CNT_W-1:0]      req_count;
    logic [rename_pkg::FREE_CNT_W-1:0]     req_wide;
    logic [rename_pkg::FREE_CNT_W:0]       avail;
    logic [rename_pkg::FREE_CNT_W-1:0]     fwd_idx;
    logic [rename_pkg::REQ_CNT_W-1:0]      fwd_count;
    logic [rename_pkg::REQ_CNT_W-1:0]      queue_take;
    logic [rename_pkg::REL_CNT_W-1:0]      write_count;
    logic [rename_pkg::FREE_PTR_W-1:0]     wr_base;
    logic [rename_pkg::FREE_CNT_W-1:0]     count_next;

    // ===================================================================
    // allocation
    // ===================================================================
    // requests are served in slot order, head entries first, then
    // this cycle's releases in list order once the queue runs dry
    always_comb begin
        req_count    = '0;
        fwd_idx      = '0;
        alloc_phys_o = '0;
        for (int i = 0; i < rename_pkg::DISPATCH_WIDTH; i++) begin
            if (alloc_req_i[i]) begin
                if ((rename_pkg::FREE_CNT_W)'(req_count) < count_q) begin
                    // pointer sum wraps at queue size
                    alloc_phys_o[i] = queue_q[head_q + (rename_pkg::FREE_PTR_W)'(req_count)];
                end else begin
                    // forwarding path
                    fwd_idx         = (rename_pkg::FREE_CNT_W)'(req_count) - count_q;
                    alloc_phys_o[i] = release_list_i[fwd_idx].old_phys;
                end
                req_count = req_count + 1'b1;
            end
        end
    end

    assign req_wide = (rename_pkg::FREE_CNT_W)'(req_count);

    // release first, committed registers count right away
    assign avail = {1'b0, count_q} + {1'b0, (rename_pkg::FREE_CNT_W)'(release_count_i)};

    // all or nothing for the whole group
    assign alloc_ok_o = ({1'b0, req_wide} <= avail);

    // ===================================================================
    // pointer and count updates
    // ===================================================================
    always_comb begin
        fwd_count = '0;
        // requests beyond the stored entries came from the releases
        if (alloc_ok_o && (req_wide > count_q)) begin
            fwd_count = (rename_pkg::REQ_CNT_W)'(req_wide - count_q);
        end
        queue_take  = alloc_ok_o ? (req_count - fwd_count) : '0;
        // forwarded releases are consumed, not written
        write_count = release_count_i - (rename_pkg::REL_CNT_W)'(fwd_count);
        count_next  = count_q + (rename_pkg::FREE_CNT_W)'(release_count_i)
                    - (alloc_ok_o ? req_wide : '0);
    end

    // first release written lands fwd_count entries into the list
    assign wr_base = tail_q - (rename_pkg::FREE_PTR_W)'(fwd_count);

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            head_q  <= '0;
            // queue starts full, so tail sits on head
            tail_q  <= '0;
            count_q <= (rename_pkg::FREE_CNT_W)'(rename_pkg::FREE_REGS);
            for (int i = 0; i < rename_pkg::FREE_REGS; i++) begin
                // registers above the architectural ones, lowest first
                queue_q[i] <= rename_pkg::phys_idx_t'(rename_pkg::ARCH_REGS + i);
            end
        end else begin
            head_q  <= head_q + (rename_pkg::FREE_PTR_W)'(queue_take);
            tail_q  <= tail_q + (rename_pkg::FREE_PTR_W)'(write_count);
            count_q <= count_next;
            for (int j = 0; j < rename_pkg::COMMIT_WIDTH; j++) begin
                // skip entries already handed to this cycle's group
                if (release_list_i[j].valid &&
                    ((rename_pkg::REQ_CNT_W)'(j) >= fwd_count)) begin
                    queue_q[wr_base + (rename_pkg::FREE_PTR_W)'(j)] <=
                        release_list_i[j].old_phys;
                end
            end
        end
    end

    // registered count, includes last cycle's releases and allocations
    assign free_count_o = count_q;

endmodule

/* logic/map_table.sv */
`timescale 1ns/1ps

module map_table (
    input  logic                        clock,
    input  logic                        reset,
    input  rename_pkg::rename_group_t   group_i,
    input  rename_pkg::alloc_phys_t     alloc_phys_i,
    input  logic                        alloc_ok_i,
    output rename_pkg::renamed_group_t  renamed_o
);

    // speculative arch to phys map
    rename_pkg::phys_idx_t                map_q [rename_pkg::ARCH_REGS];

    // slots that really write a destination, r0 excluded
    logic [rename_pkg::DISPATCH_WIDTH-1:0] dest_write;
    logic                                  accept;

    always_comb begin
        for (int i = 0; i < rename_pkg::DISPATCH_WIDTH; i++) begin
            dest_write[i] = group_i.slots[i].dest_valid &&
                            (group_i.slots[i].dest_arch != '0);
        end
    end

    assign accept = group_i.valid && alloc_ok_i;

    // ===================================================================
    // lookup with in-group bypass
    // ===================================================================
    // map read, overridden by any older slot of the group that
    // renames the same register
    function automatic rename_pkg::phys_idx_t lookup(
        input rename_pkg::arch_idx_t arch,
        input int unsigned           slot
    );
        rename_pkg::phys_idx_t phys;
        phys = map_q[arch];
        // later older slot wins, loop runs oldest first
        for (int j = 0; j < rename_pkg::DISPATCH_WIDTH; j++) begin
            if ((j < slot) && dest_write[j] && (group_i.slots[j].dest_arch == arch)) begin
                phys = alloc_phys_i[j];
            end
        end
        // r0 hardwired to p0
        if (arch == '0) begin
            phys = '0;
        end
        return phys;
    endfunction

    always_comb begin
        renamed_o = '0;
        for (int i = 0; i < rename_pkg::DISPATCH_WIDTH; i++) begin
            renamed_o[i].dest_valid = dest_write[i];
            if (dest_write[i]) begin
                renamed_o[i].dest_phys     = alloc_phys_i[i];
                // previous mapping, freed when this uop commits
                renamed_o[i].old_dest_phys = lookup(group_i.slots[i].dest_arch, i);
            end
            renamed_o[i].src1_phys = lookup(group_i.slots[i].src1_arch, i);
            renamed_o[i].src2_phys = lookup(group_i.slots[i].src2_arch, i);
        end
    end

    // ===================================================================
    // map update
    // ===================================================================
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            // identity, rN lives in pN
            for (int a = 0; a < rename_pkg::ARCH_REGS; a++) begin
                map_q[a] <= rename_pkg::phys_idx_t'(a);
            end
        end else if (accept) begin
            // younger slot assigned last, wins on equal dest
            for (int i = 0; i < rename_pkg::DISPATCH_WIDTH; i++) begin
                if (dest_write[i]) begin
                    map_q[group_i.slots[i].dest_arch] <= alloc_phys_i[i];
                end
            end
        end
    end

endmodule

/* logic/renamed_uop_stage.sv */
`timescale 1ns/1ps

module renamed_uop_stage (
    input  logic                        clock,
    input  logic                        reset,
    input  rename_pkg::renamed_group_t  renamed_i,
    input  logic                        group_valid_i,
    input  logic                        alloc_ok_i,
    output rename_pkg::renamed_group_t  renamed_o,
    output logic                        renamed_valid_o,
    output logic                        stall_o
);

    logic accept;
    logic reject;

    // ===================================================================
    // outcome of the offered group
    // ===================================================================
    assign accept = group_valid_i && alloc_ok_i;
    // not enough registers, front end must offer the group again
    assign reject = group_valid_i && !alloc_ok_i;

    // strobes, one cycle after the group was offered
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            renamed_valid_o <= 1'b0;
            stall_o         <= 1'b0;
        end else begin
            renamed_valid_o <= accept;
            stall_o         <= reject;
        end
    end

    // ===================================================================
    // payload
    // ===================================================================
    // loads only on acceptance
    // a stalled group leaves the last result in place
    always_ff @(posedge clock) begin
        if (accept) begin
            renamed_o <= renamed_i;
        end
    end

    // downstream qualifies the payload with renamed_valid_o

endmodule

/* logic/rename_unit.sv */
`timescale 1ns/1ps

module rename_unit (
    input  logic                               clock,
    input  logic                               reset,
    input  rename_pkg::rename_group_t          rename_group_i,
    input  rename_pkg::release_list_t          commit_i,
    output rename_pkg::renamed_group_t         renamed_o,
    output logic                               renamed_valid_o,
    output logic                               stall_o,
    output logic [rename_pkg::FREE_CNT_W-1:0]  free_count_o
);

    rename_pkg::release_list_t              release_list;
    logic [rename_pkg::REL_CNT_W-1:0]       release_count;
    logic [rename_pkg::DISPATCH_WIDTH-1:0]  alloc_req;
    rename_pkg::alloc_phys_t                alloc_phys;
    logic                                   alloc_ok;
    rename_pkg::renamed_group_t             renamed_comb;

    // ===================================================================
    // per-slot allocation requests
    // ===================================================================
    // r0 destinations need no register
    always_comb begin
        for (int i = 0; i < rename_pkg::DISPATCH_WIDTH; i++) begin
            alloc_req[i] = rename_group_i.valid &&
                           rename_group_i.slots[i].dest_valid &&
                           (rename_group_i.slots[i].dest_arch != '0);
        end
    end

    // commit side
    retire_release u_retire_release (
        .commit_i        (commit_i),
        .release_list_o  (release_list),
        .release_count_o (release_count)
    );

    free_list u_free_list (
        .clock           (clock),
        .reset           (reset),
        .alloc_req_i     (alloc_req),
        .release_list_i  (release_list),
        .release_count_i (release_count),
        .alloc_phys_o    (alloc_phys),
        .alloc_ok_o      (alloc_ok),
        .free_count_o    (free_count_o)
    );

    map_table u_map_table (
        .clock        (clock),
        .reset        (reset),
        .group_i      (rename_group_i),
        .alloc_phys_i (alloc_phys),
        .alloc_ok_i   (alloc_ok),
        .renamed_o    (renamed_comb)
    );

    // output register, one cycle latency
    renamed_uop_stage u_renamed_uop_stage (
        .clock           (clock),
        .reset           (reset),
        .renamed_i       (renamed_comb),
        .group_valid_i   (rename_group_i.valid),
        .alloc_ok_i      (alloc_ok),
        .renamed_o       (renamed_o),
        .renamed_valid_o (renamed_valid_o),
        .stall_o         (stall_o)
    );

endmodule

/* tb/rename_unit_tb.sv */
`timescale 1ns/1ps

module rename_unit_tb;

    localparam int CLK_PERIOD   = 100;
    localparam int RESET_CYCLES = 5;
    // spare cycles on top of the table length before the watchdog fires
    localparam int MARGIN       = 20;

    // one table row of stimulus and hand-worked expectations
    typedef struct packed {
        rename_pkg::rename_group_t          grp;
        rename_pkg::release_list_t          rel;
        logic                               stall;
        logic [rename_pkg::FREE_CNT_W-1:0]  count;
    } row_t;

    logic                               clock;
    logic                               reset;
    rename_pkg::rename_group_t          rename_group_i;
    rename_pkg::release_list_t          commit_i;
    rename_pkg::renamed_group_t         renamed_o;
    logic                               renamed_valid_o;
    logic                               stall_o;
    logic [rename_pkg::FREE_CNT_W-1:0]  free_count_o;

    row_t                                  table_q[$];
    // reference model of the free queue and speculative map
    rename_pkg::phys_idx_t                 free_q[$];
    rename_pkg::phys_idx_t                 model_map [rename_pkg::ARCH_REGS];
    rename_pkg::rename_group_t             cur_grp;
    rename_pkg::renamed_group_t            exp_renamed;
    logic [rename_pkg::DISPATCH_WIDTH-1:0] wr;
    logic                                  model_ok;
    int                                    checks;
    int                                    errors;

    initial begin
        clock = 1'b0;
        forever #(CLK_PERIOD / 2) clock = ~clock;
    end

    rename_unit UUT (
        .clock           (clock),
        .reset           (reset),
        .rename_group_i  (rename_group_i),
        .commit_i        (commit_i),
        .renamed_o       (renamed_o),
        .renamed_valid_o (renamed_valid_o),
        .stall_o         (stall_o),
        .free_count_o    (free_count_o)
    );

    // ===================================================================
    // table construction
    // ===================================================================
    function automatic rename_pkg::rename_slot_t make_slot(
        input logic dv,
        input int   d,
        input int   s1,
        input int   s2
    );
        rename_pkg::rename_slot_t s;
        s.dest_valid = dv;
        s.dest_arch  = rename_pkg::arch_idx_t'(d);
        s.src1_arch  = rename_pkg::arch_idx_t'(s1);
        s.src2_arch  = rename_pkg::arch_idx_t'(s2);
        return s;
    endfunction

    function automatic rename_pkg::release_t make_release(input logic v, input int p);
        rename_pkg::release_t r;
        r.valid    = v;
        r.old_phys = rename_pkg::phys_idx_t'(p);
        return r;
    endfunction

    task automatic add_row(
        input logic                     gv,
        input rename_pkg::rename_slot_t s0,
        input rename_pkg::rename_slot_t s1,
        input rename_pkg::release_t     c0,
        input rename_pkg::release_t     c1,
        input logic                     stall,
        input int                       count
    );
        row_t r;
        r.grp.valid    = gv;
        r.grp.slots[0] = s0;
        r.grp.slots[1] = s1;
        r.rel[0]       = c0;
        r.rel[1]       = c1;
        r.stall        = stall;
        r.count        = (rename_pkg::FREE_CNT_W)'(count);
        table_q.push_back(r);
    endtask

    task automatic build_table();
        rename_pkg::release_t none;
        rename_pkg::rename_slot_t idle;
        none = make_release(1'b0, 0);
        idle = make_slot(1'b0, 0, 0, 0);
        // first grants with slot 1 source hitting slot 0 dest
        add_row(1'b1, make_slot(1, 1, 2, 3), make_slot(1, 2, 1, 0), none, none, 0, 30);
        // both slots write r1 and the younger one sticks
        add_row(1'b1, make_slot(1, 1, 1, 2), make_slot(1, 1, 1, 5), none, none, 0, 28);
        // slot 1 without a dest
        add_row(1'b1, make_slot(1, 3, 1, 2), make_slot(0, 4, 3, 31), none, none, 0, 27);
        // p0 release under an invalid group with live slots leaves the count alone
        add_row(1'b0, make_slot(1, 12, 1, 2), make_slot(1, 13, 3, 4),
                make_release(1'b1, 0), none, 0, 27);
        // r0 dest needs nothing while releases queue behind 63
        add_row(1'b1, make_slot(1, 0, 1, 2), make_slot(1, 5, 3, 0),
                make_release(1'b1, 2), make_release(1'b1, 1), 0, 28);
        // drain until the last pair hands back p2 then p1
        for (int k = 0; k < 14; k++) begin
            add_row(1'b1, make_slot(1, 6, 6, 7), make_slot(1, 7, 6, 0), none, none,
                    0, 26 - 2 * k);
        end
        // group of two bounces off the empty queue
        add_row(1'b1, make_slot(1, 8, 8, 6), make_slot(1, 9, 8, 7), none, none, 1, 0);
        // same group again served straight from the releases
        add_row(1'b1, make_slot(1, 8, 8, 6), make_slot(1, 9, 8, 7),
                make_release(1'b1, 32), make_release(1'b1, 34), 0, 0);
        // lone release in commit slot 1 gets compacted and forwarded
        // invalid slot 0 carries a stale register number
        add_row(1'b1, make_slot(0, 4, 9, 8), make_slot(1, 10, 9, 0),
                make_release(1'b0, 9), make_release(1'b1, 3), 0, 0);
        // invalid group naming r11 must leave the map alone
        add_row(1'b0, make_slot(1, 11, 2, 3), idle,
                make_release(1'b1, 6), make_release(1'b1, 7), 0, 2);
        // head entry goes out first while the new release goes to the tail
        add_row(1'b1, make_slot(1, 11, 10, 11), idle, make_release(1'b1, 5), none, 0, 2);
    endtask

    // ===================================================================
    // reference model
    // ===================================================================
    function automatic rename_pkg::phys_idx_t read_map(
        input rename_pkg::arch_idx_t arch,
        input int                    slot
    );
        rename_pkg::phys_idx_t phys;
        phys = model_map[arch];
        // slot 0's new register shadows the map for slot 1
        if (slot == 1 && wr[0] && cur_grp.slots[0].dest_arch == arch) begin
            phys = exp_renamed[0].dest_phys;
        end
        if (arch == '0) begin
            phys = '0;
        end
        return phys;
    endfunction

    task automatic predict_row(input row_t r);
        int need;
        need        = 0;
        cur_grp     = r.grp;
        exp_renamed = '0;
        // releases count first and p0 never returns
        for (int c = 0; c < rename_pkg::COMMIT_WIDTH; c++) begin
            if (r.rel[c].valid && r.rel[c].old_phys != '0) begin
                free_q.push_back(r.rel[c].old_phys);
            end
        end
        for (int i = 0; i < rename_pkg::DISPATCH_WIDTH; i++) begin
            wr[i] = r.grp.valid && r.grp.slots[i].dest_valid && r.grp.slots[i].dest_arch != '0;
            if (wr[i]) begin
                need++;
            end
        end
        // all or nothing
        model_ok = (need <= free_q.size());
        for (int i = 0; i < rename_pkg::DISPATCH_WIDTH; i++) begin
            exp_renamed[i].dest_valid = wr[i];
            exp_renamed[i].src1_phys  = read_map(r.grp.slots[i].src1_arch, i);
            exp_renamed[i].src2_phys  = read_map(r.grp.slots[i].src2_arch, i);
            if (wr[i] && model_ok) begin
                exp_renamed[i].old_dest_phys = read_map(r.grp.slots[i].dest_arch, i);
                exp_renamed[i].dest_phys     = free_q.pop_front();
            end
        end
        if (model_ok) begin
            for (int i = 0; i < rename_pkg::DISPATCH_WIDTH; i++) begin
                if (wr[i]) begin
                    model_map[r.grp.slots[i].dest_arch] = exp_renamed[i].dest_phys;
                end
            end
        end
    endtask

    // ===================================================================
    // checking
    // ===================================================================
    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] want);
        checks++;
        if (got !== want) begin
            errors++;
            $display("** Error: %s is %h, expected %h", name, got, want);
        end
    endtask

    task automatic compare_uops();
        for (int i = 0; i < rename_pkg::DISPATCH_WIDTH; i++) begin
            check_value($sformatf("renamed_o[%0d].dest_valid", i),
                        renamed_o[i].dest_valid, exp_renamed[i].dest_valid);
            check_value($sformatf("renamed_o[%0d].dest_phys", i),
                        renamed_o[i].dest_phys, exp_renamed[i].dest_phys);
            check_value($sformatf("renamed_o[%0d].old_dest_phys", i),
                        renamed_o[i].old_dest_phys, exp_renamed[i].old_dest_phys);
            check_value($sformatf("renamed_o[%0d].src1_phys", i),
                        renamed_o[i].src1_phys, exp_renamed[i].src1_phys);
            check_value($sformatf("renamed_o[%0d].src2_phys", i),
                        renamed_o[i].src2_phys, exp_renamed[i].src2_phys);
        end
    endtask

    initial begin
        row_t row;
        int   row_errors;
        checks         = 0;
        errors         = 0;
        reset          = 1'b1;
        rename_group_i = '0;
        commit_i       = '0;
        build_table();
        // model reset state with identity map and 32..63 queued
        for (int a = 0; a < rename_pkg::ARCH_REGS; a++) begin
            model_map[a] = rename_pkg::phys_idx_t'(a);
        end
        for (int i = 0; i < rename_pkg::FREE_REGS; i++) begin
            free_q.push_back(rename_pkg::phys_idx_t'(rename_pkg::ARCH_REGS + i));
        end
        repeat (RESET_CYCLES) @(posedge clock);
        reset <= 1'b0;
        @(negedge clock);
        check_value("free_count_o", free_count_o, rename_pkg::FREE_REGS);
        check_value("renamed_valid_o", renamed_valid_o, 0);
        check_value("stall_o", stall_o, 0);
        $display("reset state checked, %0d errors", errors);
        foreach (table_q[n]) begin
            row        = table_q[n];
            row_errors = errors;
            @(posedge clock);
            rename_group_i <= row.grp;
            commit_i       <= row.rel;
            predict_row(row);
            // idle cycle behind each row since the result shows one edge later
            @(posedge clock);
            rename_group_i <= '0;
            commit_i       <= '0;
            @(negedge clock);
            check_value("stall_o", stall_o, row.stall);
            check_value("renamed_valid_o", renamed_valid_o, row.grp.valid && !row.stall);
            check_value("free_count_o", free_count_o, row.count);
            if (row.grp.valid && model_ok) begin
                compare_uops();
            end
            if (errors == row_errors) begin
                $display("row %0d passed", n);
            end else begin
                $display("row %0d failed with %0d errors", n, errors - row_errors);
            end
        end
        $display("%0d rows, %0d checks, %0d errors", table_q.size(), checks, errors);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

    // watchdog waits for the table to be built at time zero
    initial begin
        int limit;
        #1;
        limit = 2 * table_q.size() + RESET_CYCLES + MARGIN;
        #(limit * CLK_PERIOD);
        $display("simulation hung, rows not finished after %0d cycles", limit);
        $display("TEST FAIL");
        $finish;
    end

endmodule

/* rename_unit.f */
logic/rename_pkg.sv
logic/retire_release.sv
logic/free_list.sv
logic/map_table.sv
logic/renamed_uop_stage.sv
logic/rename_unit.sv
tb/rename_unit_tb.sv

/* Bender.yml */
package:
  name: rename_unit

sources:
  # package first, then leaf blocks, then the top level
  - logic/rename_pkg.sv
  - logic/retire_release.sv
  - logic/free_list.sv
  - logic/map_table.sv
  - logic/renamed_uop_stage.sv
  - logic/rename_unit.sv

  # testbench, top module rename_unit_tb
  - target: test
    files:
      - tb/rename_unit_tb.sv

# simulation sources in compile order
# also listed in rename_unit.f
